/* list.f */
+incdir+source
source/snn_pkg.sv
source/snn_input_loader.sv
source/snn_encoder.sv
source/snn_distance.sv
source/snn_top.sv
verification/snn_chk.sv
verification/snn_tb.sv

/* run.sh */
#!/bin/sh
# compile and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module snn_tb -f list.f -o snn_sim

status=0
./obj_dir/snn_sim > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Done: no errors" sim.log; then
	echo "simulation passed"
	exit 0
else
	echo "simulation failed (exit status $status)"
	exit 1
fi

/* verification/snn_tb.sv */
`timescale 1ns/100ps
`include "snn_consts.svh"

module snn_tb
	import snn_pkg::*;
();

	localparam int SET_LEN = 2 * `SNN_IMG_DIM * `SNN_IMG_DIM;
	localparam int IMG_PIX = `SNN_IMG_DIM * `SNN_IMG_DIM;
	localparam int FMAP_PIX = `SNN_FMAP_DIM * `SNN_FMAP_DIM;
	localparam int POOL_WIN = `SNN_FMAP_DIM / `SNN_POOL_DIM;
	localparam int N_RANDOM = 200;
	localparam int N_BURST = 8;
	// every set including the aborted one
	localparam int N_SETS = 3 + N_RANDOM + N_BURST + 2;
	localparam int WATCHDOG_NS = N_SETS * (SET_LEN + 1 + 30) * 20 + 1000;
	localparam int DRAIN_CYCLES = 40;

	logic clk;
	logic rst_n;
	logic in_valid;
	pixel_t img;
	pixel_t ker;
	pixel_t weight;
	logic out_valid;
	dist_t out_data;

	dist_t exp_q[$];
	string name_q[$];
	int n_pushed;
	int n_seen;

	snn_top i_snn_top (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.img       (img),
		.ker       (ker),
		.weight    (weight),
		.out_valid (out_valid),
		.out_data  (out_data)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic abort_run();
		$display("Done: errors found");
		$fatal(1, "stopping after the first error");
	endtask

	task automatic check_dist(input string name, input dist_t expected, input dist_t actual);
		if (actual !== expected) begin
			$display("** Error: %s: expected %0d, actual %0d", name, expected, actual);
			abort_run();
		end
	endtask

	// encoding of one image from the arithmetic rules
	function automatic snn_code_t ref_code(input snn_image_t im, input snn_params_t p);
		int qmap [FMAP_PIX];
		int pool [`SNN_POOL_DIM * `SNN_POOL_DIM];
		int s;
		int m;
		int idx;
		snn_code_t code;
		for (int r = 0; r < `SNN_FMAP_DIM; r++) begin
			for (int c = 0; c < `SNN_FMAP_DIM; c++) begin
				s = 0;
				for (int kr = 0; kr < `SNN_KER_DIM; kr++) begin
					for (int kc = 0; kc < `SNN_KER_DIM; kc++) begin
						s += int'(im.pix[(r + kr) * `SNN_IMG_DIM + c + kc]) *
							int'(p.ker[kr * `SNN_KER_DIM + kc]);
					end
				end
				qmap[r * `SNN_FMAP_DIM + c] = s / `SNN_Q_SCALE_CONV;
			end
		end
		for (int pr = 0; pr < `SNN_POOL_DIM; pr++) begin
			for (int pc = 0; pc < `SNN_POOL_DIM; pc++) begin
				m = 0;
				for (int dr = 0; dr < POOL_WIN; dr++) begin
					for (int dc = 0; dc < POOL_WIN; dc++) begin
						idx = (pr * POOL_WIN + dr) * `SNN_FMAP_DIM + pc * POOL_WIN + dc;
						if (qmap[idx] > m) begin
							m = qmap[idx];
						end
					end
				end
				pool[pr * `SNN_POOL_DIM + pc] = m;
			end
		end
		for (int r = 0; r < `SNN_POOL_DIM; r++) begin
			for (int c = 0; c < `SNN_POOL_DIM; c++) begin
				s = pool[r * 2] * int'(p.w[c]) + pool[r * 2 + 1] * int'(p.w[2 + c]);
				code.q[r * `SNN_POOL_DIM + c] = pixel_t'(s / `SNN_Q_SCALE_FC);
			end
		end
		return code;
	endfunction

	function automatic dist_t ref_dist(input snn_image_t a, input snn_image_t b,
		input snn_params_t p);
		snn_code_t ca;
		snn_code_t cb;
		int sum;
		ca = ref_code(a, p);
		cb = ref_code(b, p);
		sum = 0;
		for (int i = 0; i < `SNN_CODE_LEN; i++) begin
			sum += (ca.q[i] > cb.q[i]) ? int'(ca.q[i] - cb.q[i]) : int'(cb.q[i] - ca.q[i]);
		end
		return (sum < `SNN_ACT_THRESHOLD) ? dist_t'(0) : dist_t'(sum);
	endfunction

	function automatic snn_image_t rand_image(input int lo);
		snn_image_t im;
		for (int i = 0; i < IMG_PIX; i++) begin
			im.pix[i] = pixel_t'($urandom_range(255, lo));
		end
		return im;
	endfunction

	function automatic snn_params_t rand_params(input int lo);
		snn_params_t p;
		for (int i = 0; i < `SNN_KER_DIM * `SNN_KER_DIM; i++) begin
			p.ker[i] = pixel_t'($urandom_range(255, lo));
		end
		for (int i = 0; i < `SNN_POOL_DIM * `SNN_POOL_DIM; i++) begin
			p.w[i] = pixel_t'($urandom_range(255, lo));
		end
		return p;
	endfunction

	task automatic expect_set(input string name, input snn_image_t a, input snn_image_t b,
		input snn_params_t p);
		exp_q.push_back(ref_dist(a, b, p));
		name_q.push_back(name);
		n_pushed++;
	endtask

	// one cycle of a set at stream position t
	task automatic drive_beat(input snn_image_t a, input snn_image_t b, input snn_params_t p,
		input int t);
		@(posedge clk);
		in_valid <= 1'b1;
		img <= (t < IMG_PIX) ? a.pix[t] : b.pix[t - IMG_PIX];
		ker <= (t < 9) ? p.ker[t] : '0;
		weight <= (t < 4) ? p.w[t] : '0;
	endtask

	// full set followed by a single idle cycle
	task automatic send_set(input snn_image_t a, input snn_image_t b, input snn_params_t p);
		for (int t = 0; t < SET_LEN; t++) begin
			drive_beat(a, b, p, t);
		end
		@(posedge clk);
		in_valid <= 1'b0;
		img <= '0;
		ker <= '0;
		weight <= '0;
	endtask

	task automatic wait_outputs();
		int waited;
		waited = 0;
		while (exp_q.size() != 0 && waited < DRAIN_CYCLES) begin
			@(posedge clk);
			waited++;
		end
		if (exp_q.size() != 0) begin
			$display("a set produced no output within %0d cycles (%s)", DRAIN_CYCLES,
				name_q[0]);
			abort_run();
		end
	endtask

	// compare every output pulse against the oldest pending set
	initial begin
		dist_t exp_v;
		string name_v;
		forever begin
			@(negedge clk);
			if (out_valid === 1'b1) begin
				if (exp_q.size() == 0) begin
					$display("out_valid pulsed with no set pending, out_data %0d", out_data);
					abort_run();
				end else begin
					exp_v = exp_q.pop_front();
					name_v = name_q.pop_front();
					check_dist(name_v, exp_v, out_data);
					n_seen++;
				end
			end
		end
	end

	initial begin
		#(WATCHDOG_NS);
		$display("timeout, the run did not finish in %0d ns", WATCHDOG_NS);
		abort_run();
	end

	initial begin
		snn_image_t a;
		snn_image_t b;
		snn_params_t p;
		int idx;
		void'($urandom(32'hd5e1_0d8b));
		rst_n = 1'b0;
		in_valid = 1'b0;
		img = '0;
		ker = '0;
		weight = '0;
		n_pushed = 0;
		n_seen = 0;
		repeat (2) @(posedge clk);
		rst_n <= 1'b1;
		repeat (2) @(posedge clk);

		a = '0;
		p = '0;
		expect_set("all_zero", a, a, p);
		send_set(a, a, p);
		wait_outputs();
		repeat (25) @(posedge clk);
		if (n_seen != 1) begin
			$display("all-zero set gave %0d output pulses instead of one", n_seen);
			abort_run();
		end

		a = rand_image(0);
		p = rand_params(0);
		expect_set("identical", a, a, p);
		send_set(a, a, p);
		wait_outputs();

		// a few LSB flips stay under the activation threshold
		a = rand_image(0);
		b = a;
		p = rand_params(64);
		for (int i = 0; i < 3; i++) begin
			idx = $urandom_range(IMG_PIX - 1, 0);
			b.pix[idx] = a.pix[idx] ^ 8'h01;
		end
		expect_set("slight_diff", a, b, p);
		send_set(a, b, p);
		wait_outputs();

		for (int n = 0; n < N_RANDOM; n++) begin
			a = rand_image(96);
			b = rand_image(96);
			p = rand_params(128);
			expect_set("random", a, b, p);
			send_set(a, b, p);
			wait_outputs();
		end

		// one idle cycle between sets so the encoders overlap
		for (int n = 0; n < N_BURST; n++) begin
			a = rand_image(64);
			b = rand_image(64);
			p = rand_params(128);
			expect_set("back_to_back", a, b, p);
			send_set(a, b, p);
		end
		wait_outputs();

		// reset in the middle of image 1 while the stream carries on to the end
		a = rand_image(64);
		b = rand_image(64);
		p = rand_params(128);
		for (int t = 0; t < SET_LEN; t++) begin
			drive_beat(a, b, p, t);
			if (t == 50) begin
				rst_n <= 1'b0;
			end else if (t == 52) begin
				rst_n <= 1'b1;
			end
		end
		@(posedge clk);
		in_valid <= 1'b0;
		img <= '0;
		ker <= '0;
		weight <= '0;
		repeat (30) @(posedge clk);
		expect_set("after_reset", a, b, p);
		send_set(a, b, p);
		wait_outputs();
		repeat (5) @(posedge clk);

		if (exp_q.size() != 0 || n_seen != n_pushed) begin
			$display("%0d sets sent but %0d outputs seen", n_pushed, n_seen);
			abort_run();
		end else begin
			$display("Done: no errors");
			$finish;
		end
	end

endmodule

/* verification/snn_chk.sv */
`timescale 1ns/100ps
`include "snn_consts.svh"

module snn_chk
	import snn_pkg::*;
(
	input logic  clk,
	input logic  rst_n,
	input logic  out_valid,
	input dist_t out_data
);

	// output is a single-cycle pulse
	a_single_pulse: assert property (
		@(posedge clk) disable iff (!rst_n)
		out_valid |=> !out_valid
	) else $error("out_valid high two cycles in a row");

	a_zero_when_idle: assert property (
		@(posedge clk) disable iff (!rst_n)
		!out_valid |-> out_data == '0
	) else $error("out_data nonzero while out_valid is low");

	// activation clears anything below the threshold
	a_above_threshold: assert property (
		@(posedge clk) disable iff (!rst_n)
		(out_valid && out_data != '0) |-> out_data >= dist_t'(`SNN_ACT_THRESHOLD)
	) else $error("nonzero out_data below the activation threshold");

endmodule

bind snn_top snn_chk i_snn_chk (
	.clk       (clk),
	.rst_n     (rst_n),
	.out_valid (out_valid),
	.out_data  (out_data)
);

/* source/snn_top.sv */
`timescale 1ns/100ps
`include "snn_consts.svh"

module snn_top
	import snn_pkg::*;
(
	input  logic   clk,
	input  logic   rst_n,
	input  logic   in_valid,
	input  pixel_t img,
	input  pixel_t ker,
	input  pixel_t weight,
	output logic   out_valid,
	output dist_t  out_data
);

	logic [`SNN_N_IMAGES-1:0] img_valid;
	snn_image_t image;
	snn_params_t params;
	logic [`SNN_N_IMAGES-1:0] code_valid;
	snn_code_t [`SNN_N_IMAGES-1:0] code;

	snn_input_loader i_loader (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.img       (img),
		.ker       (ker),
		.weight    (weight),
		.img_valid (img_valid),
		.image     (image),
		.params    (params)
	);

	// one encoder per image of a set
	for (genvar g = 0; g < `SNN_N_IMAGES; g++) begin : g_encoder
		snn_encoder i_encoder (
			.clk        (clk),
			.rst_n      (rst_n),
			.img_valid  (img_valid[g]),
			.image      (image),
			.params     (params),
			.code_valid (code_valid[g]),
			.code       (code[g])
		);
	end

	snn_distance i_distance (
		.clk        (clk),
		.rst_n      (rst_n),
		.code_valid (code_valid),
		.code       (code),
		.out_valid  (out_valid),
		.out_data   (out_data)
	);

endmodule

/* source/snn_distance.sv */
`timescale 1ns/100ps
`include "snn_consts.svh"

module snn_distance
	import snn_pkg::*;
(
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic [`SNN_N_IMAGES-1:0]      code_valid,
	input  snn_code_t [`SNN_N_IMAGES-1:0] code,
	output logic                          out_valid,
	output dist_t                         out_data
);

	// the last encoder closes the set
	localparam int LAST = `SNN_N_IMAGES - 1;

	snn_code_t code_a;
	pixel_t diff [`SNN_CODE_LEN];
	dist_t dist_sum;

	always_ff @(posedge clk) begin
		if (code_valid[0]) begin
			code_a <= code[0];
		end
	end

	// sum of absolute byte differences
	always_comb begin
		dist_sum = '0;
		for (int i = 0; i < `SNN_CODE_LEN; i++) begin
			if (code_a.q[i] > code[LAST].q[i]) begin
				diff[i] = code_a.q[i] - code[LAST].q[i];
			end else begin
				diff[i] = code[LAST].q[i] - code_a.q[i];
			end
			dist_sum = dist_sum + dist_t'(diff[i]);
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
			out_data <= '0;
		end else begin
			out_valid <= code_valid[LAST];
			if (!code_valid[LAST]) begin
				out_data <= '0;
			end else if (dist_sum < dist_t'(`SNN_ACT_THRESHOLD)) begin
				// too close, treated as the same
				out_data <= '0;
			end else begin
				out_data <= dist_sum;
			end
		end
	end

endmodule

/* source/snn_encoder.sv */
`timescale 1ns/100ps
`include "snn_consts.svh"

module snn_encoder
	import snn_pkg::*;
(
	input  logic        clk,
	input  logic        rst_n,
	input  logic        img_valid,
	input  snn_image_t  image,
	input  snn_params_t params,
	output logic        code_valid,
	output snn_code_t   code
);

	localparam int IMG_PIX = `SNN_IMG_DIM * `SNN_IMG_DIM;
	localparam int KER_TAPS = `SNN_KER_DIM * `SNN_KER_DIM;
	localparam int FMAP_PIX = `SNN_FMAP_DIM * `SNN_FMAP_DIM;
	localparam int POOL_PIX = `SNN_POOL_DIM * `SNN_POOL_DIM;
	// side of one pooling window
	localparam int POOL_WIN = `SNN_FMAP_DIM / `SNN_POOL_DIM;
	localparam int PIX_IDX_W = $clog2(IMG_PIX);
	localparam int KER_IDX_W = $clog2(KER_TAPS);
	localparam int WIN_W = $clog2(FMAP_PIX);
	localparam logic [`SNN_CONV_W-1:0] Q_CONV = `SNN_CONV_W'(`SNN_Q_SCALE_CONV);
	localparam logic [`SNN_FC_W-1:0] Q_FC = `SNN_FC_W'(`SNN_Q_SCALE_FC);

	snn_image_t img_q;
	snn_params_t par_q;

	logic conv_run;
	logic [WIN_W-1:0] win;
	logic pool_go;
	logic fc_go;

	logic [PIX_IDX_W-1:0] win_base;
	logic [`SNN_CONV_W-1:0] conv_sum;
	pixel_t qmap [FMAP_PIX];
	pixel_t pool_max [POOL_PIX];
	pixel_t pool_q [POOL_PIX];
	logic [`SNN_FC_W-1:0] fc_sum [`SNN_CODE_LEN];
	snn_code_t fc_code;

	// sequencing: capture, 16 windows, pool, fc
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			conv_run <= 1'b0;
			win <= '0;
			pool_go <= 1'b0;
			fc_go <= 1'b0;
			code_valid <= 1'b0;
		end else begin
			pool_go <= conv_run && win == WIN_W'(FMAP_PIX - 1);
			fc_go <= pool_go;
			code_valid <= fc_go;
			if (img_valid) begin
				conv_run <= 1'b1;
				win <= '0;
			end else if (conv_run) begin
				win <= win + WIN_W'(1);
				if (win == WIN_W'(FMAP_PIX - 1)) begin
					conv_run <= 1'b0;
				end
			end
		end
	end

	// private copies, the loader refills its buffers meanwhile
	always_ff @(posedge clk) begin
		if (img_valid) begin
			img_q <= image;
			par_q <= params;
		end
	end

	// top left pixel of the current window
	assign win_base = PIX_IDX_W'((int'(win) / `SNN_FMAP_DIM) * `SNN_IMG_DIM +
		int'(win) % `SNN_FMAP_DIM);

	always_comb begin
		conv_sum = '0;
		for (int kr = 0; kr < `SNN_KER_DIM; kr++) begin
			for (int kc = 0; kc < `SNN_KER_DIM; kc++) begin
				conv_sum = conv_sum +
					`SNN_CONV_W'(img_q.pix[win_base + PIX_IDX_W'(kr * `SNN_IMG_DIM + kc)]) *
					`SNN_CONV_W'(par_q.ker[KER_IDX_W'(kr * `SNN_KER_DIM + kc)]);
			end
		end
	end

	// truncating quantization, fits a byte
	always_ff @(posedge clk) begin
		if (conv_run) begin
			qmap[win] <= pixel_t'(conv_sum / Q_CONV);
		end
	end

	// max of each quadrant
	always_comb begin
		for (int pr = 0; pr < `SNN_POOL_DIM; pr++) begin
			for (int pc = 0; pc < `SNN_POOL_DIM; pc++) begin
				pool_max[pr * `SNN_POOL_DIM + pc] =
					qmap[pr * POOL_WIN * `SNN_FMAP_DIM + pc * POOL_WIN];
				for (int dr = 0; dr < POOL_WIN; dr++) begin
					for (int dc = 0; dc < POOL_WIN; dc++) begin
						if (qmap[(pr * POOL_WIN + dr) * `SNN_FMAP_DIM + pc * POOL_WIN + dc] >
							pool_max[pr * `SNN_POOL_DIM + pc]) begin
							pool_max[pr * `SNN_POOL_DIM + pc] =
								qmap[(pr * POOL_WIN + dr) * `SNN_FMAP_DIM +
								pc * POOL_WIN + dc];
						end
					end
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (pool_go) begin
			pool_q <= pool_max;
		end
	end

	// out(r,c) = pool(r,0)*w(0,c) + pool(r,1)*w(1,c)
	always_comb begin
		for (int r = 0; r < `SNN_POOL_DIM; r++) begin
			for (int c = 0; c < `SNN_POOL_DIM; c++) begin
				fc_sum[r * `SNN_POOL_DIM + c] = '0;
				for (int i = 0; i < `SNN_POOL_DIM; i++) begin
					fc_sum[r * `SNN_POOL_DIM + c] = fc_sum[r * `SNN_POOL_DIM + c] +
						`SNN_FC_W'(pool_q[r * `SNN_POOL_DIM + i]) *
						`SNN_FC_W'(par_q.w[i * `SNN_POOL_DIM + c]);
				end
				fc_code.q[r * `SNN_POOL_DIM + c] =
					pixel_t'(fc_sum[r * `SNN_POOL_DIM + c] / Q_FC);
			end
		end
	end

	// held until the next set
	always_ff @(posedge clk) begin
		if (fc_go) begin
			code <= fc_code;
		end
	end

endmodule

/* source/snn_input_loader.sv */
`timescale 1ns/100ps
`include "snn_consts.svh"

module snn_input_loader
	import snn_pkg::*;
(
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     in_valid,
	input  pixel_t                   img,
	input  pixel_t                   ker,
	input  pixel_t                   weight,
	output logic [`SNN_N_IMAGES-1:0] img_valid,
	output snn_image_t               image,
	output snn_params_t              params
);

	localparam int IMG_PIX = `SNN_IMG_DIM * `SNN_IMG_DIM;
	localparam int KER_TAPS = `SNN_KER_DIM * `SNN_KER_DIM;
	localparam int N_WEIGHTS = `SNN_POOL_DIM * `SNN_POOL_DIM;
	localparam int SET_LEN = IMG_PIX * `SNN_N_IMAGES;
	localparam int POS_W = $clog2(SET_LEN);
	localparam int PIX_IDX_W = $clog2(IMG_PIX);
	localparam int KER_IDX_W = $clog2(KER_TAPS);
	localparam int W_IDX_W = $clog2(N_WEIGHTS);

	logic [POS_W-1:0] pos;
	logic [POS_W-1:0] img_base;
	logic [PIX_IDX_W-1:0] pix_idx;
	logic [KER_IDX_W-1:0] ker_idx;
	logic [W_IDX_W-1:0] w_idx;

	// stream position, back to zero on any gap
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pos <= '0;
		end else if (!in_valid || pos == POS_W'(SET_LEN - 1)) begin
			pos <= '0;
		end else begin
			pos <= pos + POS_W'(1);
		end
	end

	// first position of the image being streamed
	always_comb begin
		img_base = '0;
		for (int k = 1; k < `SNN_N_IMAGES; k++) begin
			if (pos >= POS_W'(k * IMG_PIX)) begin
				img_base = POS_W'(k * IMG_PIX);
			end
		end
	end

	assign pix_idx = PIX_IDX_W'(pos - img_base);
	assign ker_idx = pos[KER_IDX_W-1:0];
	assign w_idx = pos[W_IDX_W-1:0];

	// pulse once the last pixel of image k is in
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			img_valid <= '0;
		end else begin
			for (int k = 0; k < `SNN_N_IMAGES; k++) begin
				img_valid[k] <= in_valid && pos == POS_W'((k + 1) * IMG_PIX - 1);
			end
		end
	end

	// one buffer reused by every image of the set
	always_ff @(posedge clk) begin
		if (in_valid) begin
			image.pix[pix_idx] <= img;
		end
	end

	always_ff @(posedge clk) begin
		if (in_valid && pos < POS_W'(KER_TAPS)) begin
			params.ker[ker_idx] <= ker;
		end
		if (in_valid && pos < POS_W'(N_WEIGHTS)) begin
			params.w[w_idx] <= weight;
		end
	end

endmodule

/* source/snn_pkg.sv */
`include "snn_consts.svh"

package snn_pkg;

	// one pixel, kernel tap, weight or code byte
	typedef logic [`SNN_PIX_W-1:0] pixel_t;

	// L1 distance and output word
	typedef logic [`SNN_DIST_W-1:0] dist_t;

	// row-major, pix[0] is the top left pixel
	typedef struct packed {
		pixel_t [`SNN_IMG_DIM*`SNN_IMG_DIM-1:0] pix;
	} snn_image_t;

	// kernel row-major, weights w00 w01 w10 w11
	typedef struct packed {
		pixel_t [`SNN_KER_DIM*`SNN_KER_DIM-1:0] ker;
		pixel_t [`SNN_POOL_DIM*`SNN_POOL_DIM-1:0] w;
	} snn_params_t;

	// bytes ordered (0,0) (0,1) (1,0) (1,1)
	typedef struct packed {
		pixel_t [`SNN_CODE_LEN-1:0] q;
	} snn_code_t;

endpackage

/* source/snn_consts.svh */
`ifndef SNN_CONSTS_SVH
`define SNN_CONSTS_SVH

// geometry
`define SNN_PIX_W           8
`define SNN_IMG_DIM         6
`define SNN_KER_DIM         3
`define SNN_FMAP_DIM        4
`define SNN_POOL_DIM        2
`define SNN_CODE_LEN        4
`define SNN_N_IMAGES        2

// datapath widths
`define SNN_CONV_W          20
`define SNN_FC_W            17
`define SNN_DIST_W          10

// quantization and activation
`define SNN_Q_SCALE_CONV    2295
`define SNN_Q_SCALE_FC      510
`define SNN_ACT_THRESHOLD   16

// img_valid to code_valid, in cycles
`define SNN_ENC_LATENCY     19

`endif
